//--- hdl/mstr_ll_cfg.svh
//----------------------------------------------------------
// Sizing of the block manager: pool depth, list counts and
// pointer widths. Include wherever a module needs the sizes.
//----------------------------------------------------------
`ifndef MSTR_LL_CFG_SVH
`define MSTR_LL_CFG_SVH

// Block pool
`define MSTR_FL_DEPTH  16      // Buffer blocks in the pool
`define MSTR_PTR_W     4       // Block pointer width
`define MSTR_CNT_W     5       // FL count, 0 to depth inclusive

// Per-queue lists
`define MSTR_NUM_LLS   4
`define MSTR_LL_IDX_W  2

// Request lists, one per request type
`define MSTR_NUM_RLS   3
`define MSTR_RL_IDX_W  2       // Index 3 unused

// Readback word: valid, head, tail
`define MSTR_STATUS_W  9

`endif

//--- hdl/mstr_ll_pkg.sv
//----------------------------------------------------------
// Types shared by the block manager modules. Modules pull
// these in with a wildcard import in their header.
//----------------------------------------------------------
`default_nettype none

`include "mstr_ll_cfg.svh"

package mstr_ll_pkg;

  // Pointer to one buffer block
  typedef logic [`MSTR_PTR_W-1:0]    blk_ptr_t;

  // FL occupancy, needs one bit above the pointer
  typedef logic [`MSTR_CNT_W-1:0]    fl_cnt_t;

  // List selectors
  typedef logic [`MSTR_LL_IDX_W-1:0] ll_idx_t;
  typedef logic [`MSTR_RL_IDX_W-1:0] rl_idx_t;

  // Readback word, {valid, head, tail} or a zero-extended link
  typedef logic [`MSTR_STATUS_W-1:0] ll_status_t;

endpackage

`default_nettype wire

//--- hdl/blk_link_ram.sv
//----------------------------------------------------------
// Next-pointer array shared by the FL, LL and RL chains.
// One link write port per list controller, four async reads.
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mstr_ll_cfg.svh"

module blk_link_ram
  import mstr_ll_pkg::*;
(
   input  wire logic      prim_nonflr_clk
  ,input  wire logic      prim_gated_rst_b
  ,input  wire logic      fl_wr            // Link at FL tail
  ,input  wire blk_ptr_t  fl_wr_addr
  ,input  wire blk_ptr_t  fl_wr_data
  ,input  wire logic      ll_wr            // Link at LL tail
  ,input  wire blk_ptr_t  ll_wr_addr
  ,input  wire blk_ptr_t  ll_wr_data
  ,input  wire logic      rl_wr            // Link at RL tail
  ,input  wire blk_ptr_t  rl_wr_addr
  ,input  wire blk_ptr_t  rl_wr_data
  ,input  wire blk_ptr_t  fl_rd_addr
  ,input  wire blk_ptr_t  ll_rd_addr
  ,input  wire blk_ptr_t  rl_rd_addr
  ,input  wire blk_ptr_t  st_rd_addr
  ,output blk_ptr_t       fl_rd_next
  ,output blk_ptr_t       ll_rd_next
  ,output blk_ptr_t       rl_rd_next
  ,output blk_ptr_t       st_rd_next
);

  blk_ptr_t link_q [`MSTR_FL_DEPTH];   // Next pointer per block

  // Reset builds the initial FL chain 0 -> 1 -> .. -> 15
  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      for (int i = 0; i < `MSTR_FL_DEPTH; i++) begin
        link_q[i] <= blk_ptr_t'((i + 1) % `MSTR_FL_DEPTH);  // Last wraps to 0
      end
    end else begin
      if (fl_wr) link_q[fl_wr_addr] <= fl_wr_data;
      if (ll_wr) link_q[ll_wr_addr] <= ll_wr_data;
      if (rl_wr) link_q[rl_wr_addr] <= rl_wr_data;
    end
  end

  assign fl_rd_next = link_q[fl_rd_addr];   // Current links, no bypass
  assign ll_rd_next = link_q[ll_rd_addr];
  assign rl_rd_next = link_q[rl_rd_addr];
  assign st_rd_next = link_q[st_rd_addr];   // Register readback

  // Tails of three disjoint lists, so never the same block
  a_link_wr_unique : assert property (@(posedge prim_nonflr_clk)
    disable iff (!prim_gated_rst_b)
    !(fl_wr && ll_wr && (fl_wr_addr == ll_wr_addr)) &&
    !(fl_wr && rl_wr && (fl_wr_addr == rl_wr_addr)) &&
    !(ll_wr && rl_wr && (ll_wr_addr == rl_wr_addr)))
    else $error("link writes collide on one block");

endmodule

`default_nettype wire

//--- hdl/fl_ctl.sv
//----------------------------------------------------------
// Free list controller: head, tail, occupancy and flags.
// Pops feed the LLs, pushes return blocks that left an RL.
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mstr_ll_cfg.svh"

module fl_ctl
  import mstr_ll_pkg::*;
(
   input  wire logic      prim_nonflr_clk
  ,input  wire logic      prim_gated_rst_b
  ,input  wire logic      fl2ll_v          // Pop head
  ,input  wire logic      fl_push          // Push at tail
  ,input  wire blk_ptr_t  fl_push_ptr
  ,input  wire blk_ptr_t  fl_limit         // Almost-empty limit
  ,input  wire blk_ptr_t  fl_next          // Link of head block
  ,output blk_ptr_t       fl_hptr
  ,output fl_cnt_t        fl_cnt
  ,output logic           fl_empty
  ,output logic           fl_aempty        // Count <= limit
  ,output logic           fl_full
  ,output logic           fl_wr
  ,output blk_ptr_t       fl_wr_addr
  ,output blk_ptr_t       fl_wr_data
  ,output blk_ptr_t       fl_rd_addr
);

  blk_ptr_t tptr_q;
  blk_ptr_t hptr_next;
  blk_ptr_t tptr_next;
  fl_cnt_t  cnt_next;
  logic     emptying;

  // Empty now, or last block leaves this cycle
  assign emptying = fl_empty | (fl2ll_v & (fl_cnt == fl_cnt_t'(1)));

  // Push links behind the tail unless it becomes the head
  assign fl_wr      = fl_push & ~emptying;
  assign fl_wr_addr = tptr_q;
  assign fl_wr_data = fl_push_ptr;
  assign fl_rd_addr = fl_hptr;

  //----------------------------------------------------------
  // Next state, pop applied before push
  always_comb begin
    hptr_next = fl_hptr;
    tptr_next = tptr_q;
    cnt_next  = fl_cnt;
    if (fl2ll_v) begin
      hptr_next = fl_next;                 // Follow link
      cnt_next  = cnt_next - fl_cnt_t'(1);
    end
    if (fl_push) begin
      tptr_next = fl_push_ptr;
      cnt_next  = cnt_next + fl_cnt_t'(1);
      if (emptying) hptr_next = fl_push_ptr;   // Sole block
    end
  end

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      fl_hptr   <= '0;
      tptr_q    <= blk_ptr_t'(`MSTR_FL_DEPTH - 1);
      fl_cnt    <= fl_cnt_t'(`MSTR_FL_DEPTH);   // Whole pool free
      fl_empty  <= 1'b0;
      fl_aempty <= 1'b0;
      fl_full   <= 1'b1;
    end else begin
      fl_hptr   <= hptr_next;
      tptr_q    <= tptr_next;
      fl_cnt    <= cnt_next;
      fl_empty  <= (cnt_next == '0);
      fl_aempty <= (cnt_next <= fl_cnt_t'(fl_limit));
      fl_full   <= (cnt_next == fl_cnt_t'(`MSTR_FL_DEPTH));
    end
  end

  a_fl_no_underflow : assert property (@(posedge prim_nonflr_clk)
    disable iff (!prim_gated_rst_b) fl2ll_v |-> !fl_empty)
    else $error("FL pop while empty");

  a_fl_no_overflow : assert property (@(posedge prim_nonflr_clk)
    disable iff (!prim_gated_rst_b) fl_push |-> !fl_full)
    else $error("FL push while full");

endmodule

`default_nettype wire

//--- hdl/ll_queues.sv
//----------------------------------------------------------
// Per-queue lists. FL blocks are pushed at a tail, heads are
// popped toward an RL or discarded.
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mstr_ll_cfg.svh"

module ll_queues
  import mstr_ll_pkg::*;
(
   input  wire logic                         prim_nonflr_clk
  ,input  wire logic                         prim_gated_rst_b
  ,input  wire logic                         fl2ll_v        // Push FL head block
  ,input  wire ll_idx_t                      fl2ll_ll
  ,input  wire blk_ptr_t                     fl_hptr
  ,input  wire logic                         ll2rl_v        // Pop toward an RL
  ,input  wire ll_idx_t                      ll2rl_ll
  ,input  wire logic                         ll2db_v        // Pop and drop
  ,input  wire ll_idx_t                      ll2db_ll
  ,input  wire blk_ptr_t                     ll_next        // Link of popped head
  ,output logic [`MSTR_NUM_LLS-1:0]          ll_v
  ,output blk_ptr_t [`MSTR_NUM_LLS-1:0]      ll_hptr
  ,output blk_ptr_t [`MSTR_NUM_LLS-1:0]      ll_tptr
  ,output blk_ptr_t                          pop_ptr        // Block leaving an LL
  ,output logic                              ll_wr
  ,output blk_ptr_t                          ll_wr_addr
  ,output blk_ptr_t                          ll_wr_data
  ,output blk_ptr_t                          ll_rd_addr
);

  logic                          pop_v;
  ll_idx_t                       pop_ll;
  logic                          pop_last;   // Popped list holds one block
  logic                          push_new;   // Push starts a fresh list
  logic [`MSTR_NUM_LLS-1:0]      v_next;
  blk_ptr_t [`MSTR_NUM_LLS-1:0]  hptr_next;
  blk_ptr_t [`MSTR_NUM_LLS-1:0]  tptr_next;

  assign pop_v    = ll2rl_v | ll2db_v;
  assign pop_ll   = ll2rl_v ? ll2rl_ll : ll2db_ll;
  assign pop_ptr  = ll_hptr[pop_ll];
  assign pop_last = (ll_hptr[pop_ll] == ll_tptr[pop_ll]);

  // Empty list, or its only block leaves this cycle
  assign push_new = !ll_v[fl2ll_ll] | (pop_v & (pop_ll == fl2ll_ll) & pop_last);

  assign ll_wr      = fl2ll_v & ~push_new;    // Chain behind old tail
  assign ll_wr_addr = ll_tptr[fl2ll_ll];
  assign ll_wr_data = fl_hptr;
  assign ll_rd_addr = pop_ptr;

  //----------------------------------------------------------
  // Pop written first so a push to the same list overrides it
  always_comb begin
    v_next    = ll_v;
    hptr_next = ll_hptr;
    tptr_next = ll_tptr;
    if (pop_v) begin
      if (pop_last) v_next[pop_ll] = 1'b0;
      else hptr_next[pop_ll] = ll_next;
    end
    if (fl2ll_v) begin
      tptr_next[fl2ll_ll] = fl_hptr;
      if (push_new) begin
        v_next[fl2ll_ll]    = 1'b1;
        hptr_next[fl2ll_ll] = fl_hptr;
      end
    end
  end

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      ll_v    <= '0;
      ll_hptr <= '0;
      ll_tptr <= '0;
    end else begin
      ll_v    <= v_next;
      ll_hptr <= hptr_next;
      ll_tptr <= tptr_next;
    end
  end

  a_ll_pop_valid : assert property (@(posedge prim_nonflr_clk)
    disable iff (!prim_gated_rst_b) pop_v |-> ll_v[pop_ll])
    else $error("LL pop on an empty list");

  a_ll_pop_excl : assert property (@(posedge prim_nonflr_clk)
    disable iff (!prim_gated_rst_b) !(ll2rl_v && ll2db_v))
    else $error("ll2rl and ll2db in one cycle");

endmodule

`default_nettype wire

//--- hdl/rl_queues.sv
//----------------------------------------------------------
// Request lists, one per request type. Fed from LL heads,
// drained when a request completes.
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mstr_ll_cfg.svh"

module rl_queues
  import mstr_ll_pkg::*;
(
   input  wire logic                         prim_nonflr_clk
  ,input  wire logic                         prim_gated_rst_b
  ,input  wire logic                         ll2rl_v        // Push popped LL block
  ,input  wire rl_idx_t                      ll2rl_rl
  ,input  wire blk_ptr_t                     pop_ptr
  ,input  wire logic                         rl2db_v        // Pop head
  ,input  wire rl_idx_t                      rl2db_rl
  ,input  wire blk_ptr_t                     rl_next        // Link of popped head
  ,output logic [`MSTR_NUM_RLS-1:0]          rl_v
  ,output blk_ptr_t [`MSTR_NUM_RLS-1:0]      rl_hptr
  ,output blk_ptr_t [`MSTR_NUM_RLS-1:0]      rl_tptr
  ,output logic                              rl_wr
  ,output blk_ptr_t                          rl_wr_addr
  ,output blk_ptr_t                          rl_wr_data
  ,output blk_ptr_t                          rl_rd_addr
);

  logic                          pop_last;
  logic                          push_new;
  logic [`MSTR_NUM_RLS-1:0]      v_next;
  blk_ptr_t [`MSTR_NUM_RLS-1:0]  hptr_next;
  blk_ptr_t [`MSTR_NUM_RLS-1:0]  tptr_next;

  assign pop_last = (rl_hptr[rl2db_rl] == rl_tptr[rl2db_rl]);
  assign push_new = !rl_v[ll2rl_rl] | (rl2db_v & (rl2db_rl == ll2rl_rl) & pop_last);

  assign rl_wr      = ll2rl_v & ~push_new;
  assign rl_wr_addr = rl_tptr[ll2rl_rl];
  assign rl_wr_data = pop_ptr;
  assign rl_rd_addr = rl_hptr[rl2db_rl];

  always_comb begin
    v_next    = rl_v;
    hptr_next = rl_hptr;
    tptr_next = rl_tptr;
    if (rl2db_v) begin
      if (pop_last) v_next[rl2db_rl] = 1'b0;   // Drained
      else hptr_next[rl2db_rl] = rl_next;
    end
    if (ll2rl_v) begin
      tptr_next[ll2rl_rl] = pop_ptr;
      if (push_new) begin
        v_next[ll2rl_rl]    = 1'b1;
        hptr_next[ll2rl_rl] = pop_ptr;
      end
    end
  end

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      rl_v    <= '0;
      rl_hptr <= '0;
      rl_tptr <= '0;
    end else begin
      rl_v    <= v_next;
      rl_hptr <= hptr_next;
      rl_tptr <= tptr_next;
    end
  end

  a_rl_pop_valid : assert property (@(posedge prim_nonflr_clk)
    disable iff (!prim_gated_rst_b) rl2db_v |-> rl_v[rl2db_rl])
    else $error("RL pop on an empty list");

endmodule

`default_nettype wire

//--- hdl/ll_status_rd.sv
//----------------------------------------------------------
// Register readback of list and link state. A rising read
// bit loads status, block read first, then RL, then LL.
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mstr_ll_cfg.svh"

module ll_status_rd
  import mstr_ll_pkg::*;
(
   input  wire logic                         prim_nonflr_clk
  ,input  wire logic                         prim_gated_rst_b
  ,input  wire logic                         rd_ll
  ,input  wire logic                         rd_rl
  ,input  wire logic                         rd_blk
  ,input  wire blk_ptr_t                     rd_ptr         // List or block number
  ,input  wire logic [`MSTR_NUM_LLS-1:0]     ll_v
  ,input  wire blk_ptr_t [`MSTR_NUM_LLS-1:0] ll_hptr
  ,input  wire blk_ptr_t [`MSTR_NUM_LLS-1:0] ll_tptr
  ,input  wire logic [`MSTR_NUM_RLS-1:0]     rl_v
  ,input  wire blk_ptr_t [`MSTR_NUM_RLS-1:0] rl_hptr
  ,input  wire blk_ptr_t [`MSTR_NUM_RLS-1:0] rl_tptr
  ,input  wire blk_ptr_t                     st_rd_next
  ,output blk_ptr_t                          st_rd_addr
  ,output ll_status_t                        status
);

  logic [2:0] rd_q;          // {blk, rl, ll} last cycle
  ll_idx_t    ll_sel;
  rl_idx_t    rl_sel;
  ll_status_t status_next;

  assign ll_sel     = rd_ptr[`MSTR_LL_IDX_W-1:0];
  assign rl_sel     = rd_ptr[`MSTR_RL_IDX_W-1:0];
  assign st_rd_addr = rd_ptr;

  always_comb begin
    status_next = status;    // Hold without a fresh edge
    if (rd_blk & ~rd_q[2]) begin
      status_next = {{(`MSTR_STATUS_W-`MSTR_PTR_W){1'b0}}, st_rd_next};
    end else if (rd_rl & ~rd_q[1]) begin
      status_next = '0;      // Unused RL index reads zero
      if (rl_sel < `MSTR_NUM_RLS) status_next = {rl_v[rl_sel], rl_hptr[rl_sel], rl_tptr[rl_sel]};
    end else if (rd_ll & ~rd_q[0]) begin
      status_next = {ll_v[ll_sel], ll_hptr[ll_sel], ll_tptr[ll_sel]};
    end
  end

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      rd_q   <= '0;
      status <= '0;
    end else begin
      rd_q   <= {rd_blk, rd_rl, rd_ll};
      status <= status_next;
    end
  end

endmodule

`default_nettype wire

//--- hdl/mstr_ll_top.sv
//----------------------------------------------------------
// Block manager top. Connects the free list, the LL and RL
// controllers, the shared link array and the readback.
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mstr_ll_cfg.svh"

module mstr_ll_top
  import mstr_ll_pkg::*;
(
   input  wire logic                         prim_nonflr_clk
  ,input  wire logic                         prim_gated_rst_b
  ,input  wire logic                         fl2ll_v
  ,input  wire ll_idx_t                      fl2ll_ll
  ,input  wire logic                         ll2rl_v
  ,input  wire ll_idx_t                      ll2rl_ll
  ,input  wire rl_idx_t                      ll2rl_rl
  ,input  wire logic                         ll2db_v
  ,input  wire ll_idx_t                      ll2db_ll
  ,input  wire logic                         rl2db_v
  ,input  wire rl_idx_t                      rl2db_rl
  ,input  wire logic                         fl_push
  ,input  wire blk_ptr_t                     fl_push_ptr
  ,input  wire blk_ptr_t                     fl_limit
  ,input  wire logic                         rd_ll
  ,input  wire logic                         rd_rl
  ,input  wire logic                         rd_blk
  ,input  wire blk_ptr_t                     rd_ptr
  ,output blk_ptr_t                          fl_hptr
  ,output fl_cnt_t                           fl_cnt
  ,output logic                              fl_empty
  ,output logic                              fl_aempty
  ,output logic                              fl_full
  ,output logic [`MSTR_NUM_LLS-1:0]          ll_v
  ,output blk_ptr_t [`MSTR_NUM_LLS-1:0]      ll_hptr
  ,output logic [`MSTR_NUM_RLS-1:0]          rl_v
  ,output blk_ptr_t [`MSTR_NUM_RLS-1:0]      rl_hptr
  ,output ll_status_t                        status
);

  // Link array ports
  logic     fl_wr, ll_wr, rl_wr;
  blk_ptr_t fl_wr_addr, fl_wr_data, fl_rd_addr, fl_next;
  blk_ptr_t ll_wr_addr, ll_wr_data, ll_rd_addr, ll_next;
  blk_ptr_t rl_wr_addr, rl_wr_data, rl_rd_addr, rl_next;
  blk_ptr_t st_rd_addr, st_rd_next;

  blk_ptr_t                      pop_ptr;    // LL head moving out
  blk_ptr_t [`MSTR_NUM_LLS-1:0]  ll_tptr;
  blk_ptr_t [`MSTR_NUM_RLS-1:0]  rl_tptr;

  fl_ctl u_fl_ctl (.*, .fl_next(fl_next));

  ll_queues u_ll_queues (.*, .ll_next(ll_next));

  rl_queues u_rl_queues (.*, .rl_next(rl_next));

  blk_link_ram u_blk_link_ram (
     .*
    ,.fl_rd_next (fl_next)
    ,.ll_rd_next (ll_next)
    ,.rl_rd_next (rl_next)
    ,.st_rd_next (st_rd_next)
  );

  ll_status_rd u_ll_status_rd (.*);

endmodule

`default_nettype wire

//--- sim/tb_mstr_ll.sv
//----------------------------------------------------------
// Testbench for the block manager. Drives random legal list
// traffic and register reads, checks against a list model.
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mstr_ll_cfg.svh"

module tb_mstr_ll
  import mstr_ll_pkg::*;
;

  localparam int DEPTH   = `MSTR_FL_DEPTH;
  localparam int N_DIR   = 30;                   // Reset chain reads
  localparam int N_PH1   = 1400;                 // Traffic without discards
  localparam int N_PH2   = 600;                  // Traffic with discards
  localparam int N_OPS   = N_DIR + N_PH1 + N_PH2;
  localparam int T_LIMIT = 2000 + 2 * N_OPS;

  logic prim_nonflr_clk;
  logic prim_gated_rst_b;
  logic fl2ll_v, ll2rl_v, ll2db_v, rl2db_v, fl_push;
  ll_idx_t fl2ll_ll, ll2rl_ll, ll2db_ll;
  rl_idx_t ll2rl_rl, rl2db_rl;
  blk_ptr_t fl_push_ptr, fl_limit, rd_ptr;
  logic rd_ll, rd_rl, rd_blk;
  blk_ptr_t fl_hptr;
  fl_cnt_t fl_cnt;
  logic fl_empty, fl_aempty, fl_full;
  logic [`MSTR_NUM_LLS-1:0] ll_v;
  blk_ptr_t [`MSTR_NUM_LLS-1:0] ll_hptr;
  logic [`MSTR_NUM_RLS-1:0] rl_v;
  blk_ptr_t [`MSTR_NUM_RLS-1:0] rl_hptr;
  ll_status_t status;

  // Owning list of each block (0 FL, 1..4 LL, 5..7 RL, 8 returned, 9 dropped)
  int owner [DEPTH];
  int seq [DEPTH];              // Insertion order inside a list
  int seq_ctr;
  int m_h [8];                  // Head and tail registers held when empty
  int m_t [8];
  int ret_q [$];                // Blocks back from an RL and not yet pushed
  int drops = 0;
  int errors = 0;
  int cycles = 0;
  logic [15:0] lfsr = 16'd20;
  int lim_cur = 4;
  int lim_prev = 4;             // Limit the DUT sampled at the last edge
  ll_status_t exp_status = '0;
  bit pv_ll, pv_rl, pv_blk;     // Read bits of the previous cycle

  // This cycle's strobes
  bit d_fl2ll, d_ll2rl, d_ll2db, d_rl2db, d_push, d_rd_ll, d_rd_rl, d_rd_blk;
  int d_fl2ll_ll, d_pop_ll, d_rl, d_rl2db_rl, d_push_ptr, d_rd_ptr;

  mstr_ll_top dut (.*);   // Port names match one to one

  initial begin
    prim_nonflr_clk = 1'b0;
    forever #20 prim_nonflr_clk = ~prim_nonflr_clk;
  end

  always @(posedge prim_nonflr_clk) begin
    cycles = cycles + 1;
    if (cycles >= T_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", T_LIMIT);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  //----------------------------------------------------------
  // Random source and model helpers
  //----------------------------------------------------------
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);   // One step per bit
      v = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  function automatic int list_size(input int id);
    int n;
    n = 0;
    for (int b = 0; b < DEPTH; b++) n += (owner[b] == id);
    return n;
  endfunction

  // Head (oldest) or tail (newest) block of a list or -1 when empty
  function automatic int list_end(input int id, input bit tail);
    int best;
    best = -1;
    for (int b = 0; b < DEPTH; b++) begin
      if (owner[b] == id) begin
        if (best < 0 || (tail ? seq[b] > seq[best] : seq[b] < seq[best])) best = b;
      end
    end
    return best;
  endfunction

  // Expected link word or -1 for a tail
  function automatic int next_in_list(input int b);
    int nxt;
    nxt = -1;
    for (int c = 0; c < DEPTH; c++) begin
      if (owner[c] == owner[b] && seq[c] > seq[b] && (nxt < 0 || seq[c] < seq[nxt])) nxt = c;
    end
    return nxt;
  endfunction

  task automatic move_block(input int b, input int id);
    owner[b] = id;
    seq[b]   = seq_ctr;        // Lands at the tail
    seq_ctr++;
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic compare_outputs();
    int n;
    n = list_size(0);
    compare("fl_cnt", fl_cnt, n);
    compare("fl_empty", fl_empty, n == 0);
    compare("fl_full", fl_full, n == DEPTH);
    compare("fl_aempty", fl_aempty, n <= lim_prev);
    if (n > 0) compare("fl_hptr", fl_hptr, list_end(0, 1'b0));   // Stale when empty
    for (int l = 0; l < `MSTR_NUM_LLS; l++) begin
      compare($sformatf("ll_v[%0d]", l), ll_v[l], list_size(1 + l) > 0);
      compare($sformatf("ll_hptr[%0d]", l), ll_hptr[l], m_h[1 + l]);
    end
    for (int r = 0; r < `MSTR_NUM_RLS; r++) begin
      compare($sformatf("rl_v[%0d]", r), rl_v[r], list_size(5 + r) > 0);
      compare($sformatf("rl_hptr[%0d]", r), rl_hptr[r], m_h[5 + r]);
    end
    compare("status", status, exp_status);
  endtask

  //----------------------------------------------------------
  // Stimulus picked from the model state before this edge
  //----------------------------------------------------------
  task automatic pick_strobes(input int cyc);
    bit drain;
    int l;
    int r;
    int b;
    int idx;
    int other_ll;
    drain = ((cyc / 64) % 2) == 0;   // Alternate draining and refilling the FL
    {d_fl2ll, d_ll2rl, d_ll2db, d_rl2db, d_push, d_rd_ll, d_rd_rl, d_rd_blk} = '0;
    {d_fl2ll_ll, d_pop_ll, d_rl, d_rl2db_rl, d_push_ptr} = '0;
    other_ll = 0;
    lim_prev = lim_cur;
    if (cyc < N_DIR) begin
      d_rd_blk = (cyc % 2 == 0);      // Walk the reset chain
      d_rd_ptr = cyc / 2;
    end else begin
      d_fl2ll    = list_size(0) > 0 && take_bits(3) < (drain ? 7 : 1);
      d_fl2ll_ll = take_bits(2);
      l = take_bits(2);
      for (int i = 0; i < `MSTR_NUM_LLS && list_size(1 + l) == 0; i++) l = (l + 1) % 4;
      d_pop_ll = l;
      other_ll = (l + 1 + take_bits(2) % 3) % 4;   // Idle pop index differs
      d_rl     = take_bits(2) % `MSTR_NUM_RLS;
      if (list_size(1 + l) > 0 && take_bits(2) < (drain ? 2 : 3)) begin
        if (cyc >= N_DIR + N_PH1 && drops < 6 && take_bits(2) == 0) d_ll2db = 1'b1;
        else d_ll2rl = 1'b1;
      end
      r = take_bits(2) % `MSTR_NUM_RLS;
      for (int i = 0; i < `MSTR_NUM_RLS && list_size(5 + r) == 0; i++) r = (r + 1) % 3;
      d_rl2db_rl = r;
      d_rl2db    = list_size(5 + r) > 0 && take_bits(2) < (drain ? 1 : 3);
      // Only blocks that left an RL in earlier cycles go back
      if (ret_q.size() > 0 && list_size(0) < DEPTH && take_bits(2) < (drain ? 1 : 3)) begin
        idx        = take_bits(4) % ret_q.size();
        d_push     = 1'b1;
        d_push_ptr = ret_q[idx];
        ret_q.delete(idx);
      end
      if (take_bits(4) == 0) lim_cur = take_bits(4);
      d_rd_ll  = take_bits(1);
      d_rd_rl  = take_bits(1);
      d_rd_ptr = take_bits(4);
      d_rd_blk = take_bits(1);
      if (d_rd_blk && !pv_blk) begin
        b = d_rd_ptr;              // Find a block whose link is defined
        for (int i = 0; i < DEPTH && !(owner[b] < 8 && next_in_list(b) >= 0); i++) begin
          b = (b + 1) % DEPTH;
        end
        if (owner[b] < 8 && next_in_list(b) >= 0) d_rd_ptr = b;
        else d_rd_blk = 1'b0;
      end
    end
    fl2ll_v     <= d_fl2ll;
    fl2ll_ll    <= ll_idx_t'(d_fl2ll_ll);
    ll2rl_v     <= d_ll2rl;
    ll2db_v     <= d_ll2db;
    ll2rl_ll    <= ll_idx_t'(d_ll2db ? other_ll : d_pop_ll);
    ll2db_ll    <= ll_idx_t'(d_ll2db ? d_pop_ll : other_ll);
    ll2rl_rl    <= rl_idx_t'(d_rl);
    rl2db_v     <= d_rl2db;
    rl2db_rl    <= rl_idx_t'(d_rl2db_rl);
    fl_push     <= d_push;
    fl_push_ptr <= blk_ptr_t'(d_push_ptr);
    fl_limit    <= blk_ptr_t'(lim_cur);
    rd_ll       <= d_rd_ll;
    rd_rl       <= d_rd_rl;
    rd_blk      <= d_rd_blk;
    rd_ptr      <= blk_ptr_t'(d_rd_ptr);
  endtask

  task automatic drive_idle();
    lim_prev = lim_cur;
    {fl2ll_v, ll2rl_v, ll2db_v, rl2db_v, fl_push} <= '0;
    {rd_ll, rd_rl, rd_blk} <= '0;
  endtask

  // Status for a rising read from the state the DUT samples
  task automatic expect_status();
    int sel;
    sel = d_rd_ptr % 4;
    if (d_rd_blk && !pv_blk) begin
      exp_status = ll_status_t'(next_in_list(d_rd_ptr));
    end else if (d_rd_rl && !pv_rl) begin
      exp_status = '0;            // RL index 3 does not exist
      if (sel < `MSTR_NUM_RLS) begin
        exp_status = {list_size(5 + sel) > 0, 4'(m_h[5 + sel]), 4'(m_t[5 + sel])};
      end
    end else if (d_rd_ll && !pv_ll) begin
      exp_status = {list_size(1 + sel) > 0, 4'(m_h[1 + sel]), 4'(m_t[1 + sel])};
    end
    {pv_blk, pv_rl, pv_ll} = {d_rd_blk, d_rd_rl, d_rd_ll};
  endtask

  // Applied in the order fl2ll then LL pop then rl2db then fl_push
  task automatic apply_strobes();
    int b;
    if (d_fl2ll) move_block(list_end(0, 1'b0), 1 + d_fl2ll_ll);
    if (d_ll2rl || d_ll2db) begin
      b = list_end(1 + d_pop_ll, 1'b0);
      if (d_ll2rl) begin
        move_block(b, 5 + d_rl);
      end else begin
        move_block(b, 9);         // Gone for good
        drops++;
      end
    end
    if (d_rl2db) begin
      b = list_end(5 + d_rl2db_rl, 1'b0);
      move_block(b, 8);
      ret_q.push_back(b);
    end
    if (d_push) move_block(d_push_ptr, 0);
    for (int id = 1; id < 8; id++) begin
      if (list_size(id) > 0) begin
        m_h[id] = list_end(id, 1'b0);
        m_t[id] = list_end(id, 1'b1);
      end
    end
  endtask

  //----------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------
  initial begin
    prim_gated_rst_b = 1'b0;
    {fl2ll_v, ll2rl_v, ll2db_v, rl2db_v, fl_push, rd_ll, rd_rl, rd_blk} = '0;
    {fl2ll_ll, ll2rl_ll, ll2db_ll, ll2rl_rl, rl2db_rl} = '0;
    fl_push_ptr = '0;
    fl_limit    = blk_ptr_t'(lim_cur);
    rd_ptr      = '0;
    for (int b = 0; b < DEPTH; b++) begin
      owner[b] = 0;               // Whole pool on the FL in block order
      seq[b]   = b;
    end
    seq_ctr = DEPTH;
    for (int id = 0; id < 8; id++) begin
      m_h[id] = 0;
      m_t[id] = 0;
    end
    {pv_blk, pv_rl, pv_ll} = '0;
    repeat (5) @(posedge prim_nonflr_clk);
    prim_gated_rst_b <= 1'b1;
    @(negedge prim_nonflr_clk);
    compare_outputs();            // Reset values
    for (int c = 0; c < N_OPS; c++) begin
      @(posedge prim_nonflr_clk);
      pick_strobes(c);
      @(negedge prim_nonflr_clk);
      compare_outputs();          // State from the previous strobes
      expect_status();
      apply_strobes();
    end
    @(posedge prim_nonflr_clk);
    drive_idle();
    @(negedge prim_nonflr_clk);
    compare_outputs();
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/mstr_ll_pkg.sv
hdl/blk_link_ram.sv
hdl/fl_ctl.sv
hdl/ll_queues.sv
hdl/rl_queues.sv
hdl/ll_status_rd.sv
hdl/mstr_ll_top.sv
sim/tb_mstr_ll.sv

//--- Bender.yml
package:
  name: mstr_ll

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mstr_ll_pkg.sv
      - hdl/blk_link_ram.sv
      - hdl/fl_ctl.sv
      - hdl/ll_queues.sv
      - hdl/rl_queues.sv
      - hdl/ll_status_rd.sv
      - hdl/mstr_ll_top.sv
      - sim/tb_mstr_ll.sv
